/* axi_bridge_pkg.sv */
// axi bridge shared widths, axi encodings, fsm states and channel structs
package axi_bridge_pkg;

   // ################################################
   // widths
   // ################################################
   localparam int ADDR_W             = 32;
   localparam int PAYLOAD_P_DW_BYTES = 2;                        // log2 of 4 payload bytes
   localparam int AXI_P_DW_BYTES     = 3;                        // log2 of 8 bus bytes
   localparam int PAYLOAD_BYTES      = (1 << PAYLOAD_P_DW_BYTES);
   localparam int AXI_BYTES          = (1 << AXI_P_DW_BYTES);
   localparam int PAYLOAD_W          = PAYLOAD_BYTES * 8;
   localparam int AXI_DW             = AXI_BYTES * 8;

   // payload windows inside one bus word
   localparam int WIN_NUM            = AXI_BYTES / PAYLOAD_BYTES;
   localparam int WIN_P_NUM          = AXI_P_DW_BYTES - PAYLOAD_P_DW_BYTES; // addr bits of window

   // request queue
   localparam int QUEUE_DEPTH        = 4;
   localparam int QUEUE_AW           = 2;

   // ################################################
   // axi encodings
   // ################################################
   localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;                // 4 bytes per beat
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // transaction engine states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_ADDR_DATA,   // aw and w in flight
      ST_WR_RESP,        // waiting for b
      ST_RD_ADDR,
      ST_RD_DATA,
      ST_DONE            // response strobe cycle
   } txn_state_e;

   // ################################################
   // structs
   // ################################################
   typedef struct packed {
      logic                 we;
      logic [ADDR_W-1:0]    addr;
      logic [PAYLOAD_W-1:0] wdata;
   } bridge_req_t;

   typedef struct packed {
      logic [PAYLOAD_W-1:0] rdata;
      logic                 err;
   } bridge_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_aw_t;

   typedef axi_aw_t axi_ar_t;   // read address has the same layout

   typedef struct packed {
      logic [AXI_DW-1:0]    data;
      logic [AXI_BYTES-1:0] strb;
      logic                 last;
   } axi_w_t;

   typedef struct packed {
      axi_resp_e resp;
   } axi_b_t;

   typedef struct packed {
      logic [AXI_DW-1:0] data;
      axi_resp_e         resp;
      logic              last;
   } axi_r_t;

endpackage

/* align_w.sv */
// store aligner, drops the 32-bit payload into its window of the 64-bit bus word
`timescale 1ns/1ps

module align_w
(
   input  logic [axi_bridge_pkg::PAYLOAD_W-1:0] i_axi_din,
   input  logic                                 i_axi_we,
   input  logic [axi_bridge_pkg::ADDR_W-1:0]    i_axi_addr,
   output logic [axi_bridge_pkg::AXI_BYTES-1:0] o_axi_wstrb,
   output logic [axi_bridge_pkg::AXI_DW-1:0]    o_axi_wdata
);
   import axi_bridge_pkg::*;

   logic [AXI_BYTES-1:0] wstrb_win;   // strobes before write enable
   logic [WIN_P_NUM-1:0] win_sel;     // window index from address

   assign win_sel = i_axi_addr[PAYLOAD_P_DW_BYTES +: WIN_P_NUM];

   // ################################################
   // per window strobes and data
   // ################################################
   genvar i;
   generate
      for (i = 0; i < WIN_NUM; i = i + 1)
      begin : g_win
         // only the addressed window gets its bytes
         assign wstrb_win[i*PAYLOAD_BYTES +: PAYLOAD_BYTES] =
            {PAYLOAD_BYTES{win_sel == WIN_P_NUM'(i)}};

         // payload copied into every window, strobes pick
         assign o_axi_wdata[i*PAYLOAD_W +: PAYLOAD_W] = i_axi_din;
      end
   endgenerate

   // no strobes at all on a load
   assign o_axi_wstrb = {AXI_BYTES{i_axi_we}} & wstrb_win;

endmodule

/* align_r.sv */
// load aligner, pulls the addressed 32-bit window out of the 64-bit read data
`timescale 1ns/1ps

module align_r
(
   input  logic [axi_bridge_pkg::AXI_DW-1:0]    i_axi_rdata,
   input  logic [axi_bridge_pkg::ADDR_W-1:0]    i_axi_addr,
   output logic [axi_bridge_pkg::PAYLOAD_W-1:0] o_dout
);
   import axi_bridge_pkg::*;

   logic [PAYLOAD_W-1:0] rdata_win [WIN_NUM];   // bus word split into windows
   logic [WIN_P_NUM-1:0] win_sel;

   // same address bits as the store side
   assign win_sel = i_axi_addr[PAYLOAD_P_DW_BYTES +: WIN_P_NUM];

   // ################################################
   // window split
   // ################################################
   genvar i;
   generate
      for (i = 0; i < WIN_NUM; i = i + 1)
      begin : g_win
         assign rdata_win[i] = i_axi_rdata[i*PAYLOAD_W +: PAYLOAD_W];
      end
   endgenerate

   // pick one
   assign o_dout = rdata_win[win_sel];

endmodule

/* req_queue.sv */
// request queue, four entry circular fifo between the core strobe and the engine
`timescale 1ns/1ps

module req_queue
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_push,
   input  axi_bridge_pkg::bridge_req_t i_push_data,
   input  logic                        i_pop,
   output axi_bridge_pkg::bridge_req_t o_head,
   output logic                        o_empty
);
   import axi_bridge_pkg::*;

   bridge_req_t         mem [QUEUE_DEPTH];   // entries
   logic [QUEUE_AW-1:0] wr_ptr;
   logic [QUEUE_AW-1:0] rd_ptr;
   logic [QUEUE_AW:0]   count;               // one extra bit to reach full
   logic                full;

   assign o_empty = (count == '0);
   assign full    = (count == (QUEUE_AW+1)'(QUEUE_DEPTH));
   assign o_head  = mem[rd_ptr];              // head shows next cycle after push

   // ################################################
   // storage
   // ################################################
   always_ff @(posedge clk)
   begin
      if (i_push)
      begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (i_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (i_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // both or neither
         endcase
      end
   end

   // core stays within four outstanding, engine only pops real entries
   a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
      !(i_push && full && !i_pop));
   a_no_underflow: assert property (@(posedge clk) disable iff (i_reset)
      !(i_pop && o_empty));

endmodule

/* axi_txn_engine.sv */
// axi transaction engine that runs one single beat read or write per queued request
`timescale 1ns/1ps

module axi_txn_engine
(
   input  logic                                 clk,
   input  logic                                 i_reset,
   // queue side
   input  axi_bridge_pkg::bridge_req_t          i_head,
   input  logic                                 i_empty,
   output logic                                 o_pop,
   // aligners
   output logic [axi_bridge_pkg::PAYLOAD_W-1:0] o_wdata_payload,
   output logic                                 o_we,
   output logic [axi_bridge_pkg::ADDR_W-1:0]    o_addr,
   input  logic [axi_bridge_pkg::AXI_BYTES-1:0] i_wstrb,
   input  logic [axi_bridge_pkg::AXI_DW-1:0]    i_wdata,
   output logic [axi_bridge_pkg::AXI_DW-1:0]    o_rdata_bus,
   input  logic [axi_bridge_pkg::PAYLOAD_W-1:0] i_rdata_word,
   // axi write
   output axi_bridge_pkg::axi_aw_t              o_aw,
   output logic                                 o_awvalid,
   input  logic                                 i_awready,
   output axi_bridge_pkg::axi_w_t               o_w,
   output logic                                 o_wvalid,
   input  logic                                 i_wready,
   input  axi_bridge_pkg::axi_b_t               i_b,
   input  logic                                 i_bvalid,
   output logic                                 o_bready,
   // axi read
   output axi_bridge_pkg::axi_ar_t              o_ar,
   output logic                                 o_arvalid,
   input  logic                                 i_arready,
   input  axi_bridge_pkg::axi_r_t               i_r,
   input  logic                                 i_rvalid,
   output logic                                 o_rready,
   // core response
   output axi_bridge_pkg::bridge_rsp_t          o_rsp,
   output logic                                 o_rsp_valid
);
   import axi_bridge_pkg::*;

   txn_state_e  state;
   bridge_req_t req_q;        // request being served
   bridge_rsp_t rsp_q;
   logic        awvalid_q;    // drops on its own handshake
   logic        wvalid_q;     // independent of aw
   logic        arvalid_q;
   logic        bready_q;
   logic        rready_q;
   logic        aw_pending;   // aw still open after this edge
   logic        w_pending;
   logic        b_hs;
   logic        r_hs;

   assign aw_pending = awvalid_q && !i_awready;
   assign w_pending  = wvalid_q && !i_wready;
   assign b_hs       = bready_q && i_bvalid;
   assign r_hs       = rready_q && i_rvalid;

   assign o_pop = (state == ST_IDLE) && !i_empty;

   // aligner feeds
   assign o_wdata_payload = req_q.wdata;
   assign o_we            = req_q.we;
   assign o_addr          = req_q.addr;
   assign o_rdata_bus     = i_r.data;

   // ################################################
   // single beat incr channel payloads
   // ################################################
   assign o_aw = '{addr: req_q.addr, len: 8'd0, size: AXI_SIZE_WORD, burst: AXI_BURST_INCR};
   assign o_ar = '{addr: req_q.addr, len: 8'd0, size: AXI_SIZE_WORD, burst: AXI_BURST_INCR};
   assign o_w  = '{data: i_wdata, strb: i_wstrb, last: 1'b1};

   assign o_awvalid   = awvalid_q;
   assign o_wvalid    = wvalid_q;
   assign o_arvalid   = arvalid_q;
   assign o_bready    = bready_q;
   assign o_rready    = rready_q;
   assign o_rsp       = rsp_q;
   assign o_rsp_valid = (state == ST_DONE);   // one cycle after b or r

   // latch popped request
   always_ff @(posedge clk)
   begin
      if (o_pop)
      begin
         req_q <= i_head;
      end
   end

   // response capture
   always_ff @(posedge clk)
   begin
      if (b_hs)
      begin
         rsp_q.rdata <= '0;                   // stores return no data
         rsp_q.err   <= (i_b.resp != OKAY);
      end
      else if (r_hs)
      begin
         rsp_q.rdata <= i_rdata_word;
         rsp_q.err   <= (i_r.resp != OKAY);
      end
   end

   // ################################################
   // fsm
   // ################################################
   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         state     <= ST_IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
         bready_q  <= 1'b0;
         rready_q  <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (!i_empty)
               begin
                  if (i_head.we)
                  begin
                     state     <= ST_WR_ADDR_DATA;
                     awvalid_q <= 1'b1;     // aw and w together
                     wvalid_q  <= 1'b1;
                  end
                  else
                  begin
                     state     <= ST_RD_ADDR;
                     arvalid_q <= 1'b1;
                  end
               end
            end
            ST_WR_ADDR_DATA:
            begin
               awvalid_q <= aw_pending;
               wvalid_q  <= w_pending;
               if (!aw_pending && !w_pending)
               begin
                  state    <= ST_WR_RESP;
                  bready_q <= 1'b1;
               end
            end
            ST_WR_RESP:
            begin
               if (b_hs)
               begin
                  state    <= ST_DONE;
                  bready_q <= 1'b0;
               end
            end
            ST_RD_ADDR:
            begin
               if (i_arready)
               begin
                  state     <= ST_RD_DATA;
                  arvalid_q <= 1'b0;
                  rready_q  <= 1'b1;   // hold until r shows up
               end
            end
            ST_RD_DATA:
            begin
               if (r_hs)
               begin
                  state    <= ST_DONE;
                  rready_q <= 1'b0;
               end
            end
            ST_DONE: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // valid and payload held until ready
   a_aw_hold: assert property (@(posedge clk) disable iff (i_reset)
      o_awvalid && !i_awready |=> o_awvalid && $stable(o_aw));
   a_w_hold: assert property (@(posedge clk) disable iff (i_reset)
      o_wvalid && !i_wready |=> o_wvalid && $stable(o_w));
   a_ar_hold: assert property (@(posedge clk) disable iff (i_reset)
      o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));
   // response is a single cycle strobe
   a_rsp_pulse: assert property (@(posedge clk) disable iff (i_reset)
      o_rsp_valid |=> !o_rsp_valid);
   // pop only from a quiet engine with no channel open and no response pending
   a_pop_idle: assert property (@(posedge clk) disable iff (i_reset)
      o_pop |-> !(o_awvalid || o_wvalid || o_arvalid ||
                  o_bready || o_rready || o_rsp_valid));

endmodule

/* axi_bridge_top.sv */
// axi bridge top, core load/store port to single beat 64-bit axi4
`timescale 1ns/1ps

module axi_bridge_top
(
   input  logic                        clk,
   input  logic                        i_reset,
   // core port
   input  logic                        i_req_valid,
   input  axi_bridge_pkg::bridge_req_t i_req,
   output logic                        o_rsp_valid,
   output axi_bridge_pkg::bridge_rsp_t o_rsp,
   // axi write channels
   output axi_bridge_pkg::axi_aw_t     o_aw,
   output logic                        o_awvalid,
   input  logic                        i_awready,
   output axi_bridge_pkg::axi_w_t      o_w,
   output logic                        o_wvalid,
   input  logic                        i_wready,
   input  axi_bridge_pkg::axi_b_t      i_b,
   input  logic                        i_bvalid,
   output logic                        o_bready,
   // axi read channels
   output axi_bridge_pkg::axi_ar_t     o_ar,
   output logic                        o_arvalid,
   input  logic                        i_arready,
   input  axi_bridge_pkg::axi_r_t      i_r,
   input  logic                        i_rvalid,
   output logic                        o_rready
);
   import axi_bridge_pkg::*;

   bridge_req_t          head;         // queue head
   logic                 q_empty;
   logic                 pop;
   logic [PAYLOAD_W-1:0] wdata_payload;
   logic                 we;
   logic [ADDR_W-1:0]    addr;         // latched request address
   logic [AXI_BYTES-1:0] wstrb;
   logic [AXI_DW-1:0]    wdata_bus;
   logic [AXI_DW-1:0]    rdata_bus;
   logic [PAYLOAD_W-1:0] rdata_word;

   // ################################################
   // queue and engine
   // ################################################
   req_queue u_queue (
      .clk, .i_reset, .i_push(i_req_valid), .i_push_data(i_req),
      .i_pop(pop), .o_head(head), .o_empty(q_empty));

   axi_txn_engine u_engine (
      .clk, .i_reset, .i_head(head), .i_empty(q_empty), .o_pop(pop),
      .o_wdata_payload(wdata_payload), .o_we(we), .o_addr(addr),
      .i_wstrb(wstrb), .i_wdata(wdata_bus),
      .o_rdata_bus(rdata_bus), .i_rdata_word(rdata_word),
      .o_aw, .o_awvalid, .i_awready, .o_w, .o_wvalid, .i_wready,
      .i_b, .i_bvalid, .o_bready, .o_ar, .o_arvalid, .i_arready,
      .i_r, .i_rvalid, .o_rready, .o_rsp, .o_rsp_valid);

   // aligners, pure combinational
   align_w u_align_w (
      .i_axi_din(wdata_payload), .i_axi_we(we), .i_axi_addr(addr),
      .o_axi_wstrb(wstrb), .o_axi_wdata(wdata_bus));

   align_r u_align_r (
      .i_axi_rdata(rdata_bus), .i_axi_addr(addr), .o_dout(rdata_word));

endmodule

/* tb_axi_mem.sv */
// axi slave memory model for the testbench, random handshake delays and an error region
`timescale 1ns/1ps

module tb_axi_mem
(
   input  logic                    clk,
   input  logic                    i_reset,
   input  axi_bridge_pkg::axi_aw_t i_aw,
   input  logic                    i_awvalid,
   output logic                    o_awready,
   input  axi_bridge_pkg::axi_w_t  i_w,
   input  logic                    i_wvalid,
   output logic                    o_wready,
   output axi_bridge_pkg::axi_b_t  o_b,
   output logic                    o_bvalid,
   input  logic                    i_bready,
   input  axi_bridge_pkg::axi_ar_t i_ar,
   input  logic                    i_arvalid,
   output logic                    o_arready,
   output axi_bridge_pkg::axi_r_t  o_r,
   output logic                    o_rvalid,
   input  logic                    i_rready
);
   import axi_bridge_pkg::*;

   localparam int MEM_WORDS = 256;                 // indexed by addr[10:3]
   localparam logic [ADDR_W-1:0] ERR_BASE = 32'h8000_0000;

   logic [AXI_DW-1:0] mem [MEM_WORDS];
   integer            seed = 32'h56902c63;
   logic              rst_q = 1'b1;                // reset seen on the rising edge

   // slave outputs, all low from time zero
   logic    awready_q = 1'b0;
   logic    wready_q  = 1'b0;
   logic    arready_q = 1'b0;
   logic    bvalid_q  = 1'b0;
   logic    rvalid_q  = 1'b0;
   axi_b_t  b_q       = '0;
   axi_r_t  r_q       = '0;

   axi_aw_t aw_q;                                   // captured request payloads
   axi_w_t  w_q;
   axi_ar_t ar_q;
   bit      aw_seen, w_seen, ar_seen;              // handshake done, waiting for b or r
   bit      b_fire, r_fire;                        // handshake on the coming rising edge
   int      aw_dly, w_dly, ar_dly, b_dly, r_dly;

   assign o_awready = awready_q;
   assign o_wready  = wready_q;
   assign o_arready = arready_q;
   assign o_bvalid  = bvalid_q;
   assign o_rvalid  = rvalid_q;
   assign o_b       = b_q;
   assign o_r       = r_q;

   function automatic int next_delay();
      return $random(seed) & 3;                    // 0 to 3 cycles
   endfunction

   // ready side of one address or data channel, one call per falling edge
   task automatic ready_step(input logic valid, inout logic ready, inout bit seen,
                             inout int dly);
      if (ready)
      begin
         ready = 1'b0;                              // taken on the last rising edge
         seen  = 1'b1;
         dly   = next_delay();
      end
      else if (valid && !seen)
      begin
         if (dly == 0)
            ready = 1'b1;
         else
            dly = dly - 1;
      end
   endtask

   always @(posedge clk)
      rst_q <= i_reset;

   // ################################################
   // slave, all changes on the falling edge
   // ################################################
   always @(negedge clk)
   begin
      if (rst_q)
      begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[8'(i)] = '0;
         awready_q = 1'b0;
         wready_q  = 1'b0;
         arready_q = 1'b0;
         bvalid_q  = 1'b0;
         rvalid_q  = 1'b0;
         {aw_seen, w_seen, ar_seen, b_fire, r_fire} = '0;
         aw_dly = next_delay();
         w_dly  = next_delay();
         ar_dly = next_delay();
         b_dly  = next_delay();
         r_dly  = next_delay();
      end
      else
      begin
         // payload is held with valid, so the last copy is the transferred one
         if (i_awvalid && !awready_q) aw_q = i_aw;
         if (i_wvalid && !wready_q)   w_q  = i_w;
         if (i_arvalid && !arready_q) ar_q = i_ar;
         ready_step(i_awvalid, awready_q, aw_seen, aw_dly);
         ready_step(i_wvalid, wready_q, w_seen, w_dly);
         ready_step(i_arvalid, arready_q, ar_seen, ar_dly);

         // write response, memory updated when b goes out
         if (b_fire)
         begin
            bvalid_q = 1'b0;
            aw_seen  = 1'b0;
            w_seen   = 1'b0;
            b_dly    = next_delay();
         end
         else if (aw_seen && w_seen && !bvalid_q)
         begin
            if (b_dly == 0)
            begin
               if (aw_q.addr < ERR_BASE)
               begin
                  for (int i = 0; i < AXI_BYTES; i++)
                     if (w_q.strb[3'(i)])
                        mem[aw_q.addr[10:3]][i*8 +: 8] = w_q.data[i*8 +: 8];
               end
               b_q.resp = (aw_q.addr < ERR_BASE) ? OKAY : SLVERR;
               bvalid_q = 1'b1;
            end
            else
               b_dly = b_dly - 1;
         end
         b_fire = bvalid_q && i_bready;            // bready only moves on rising edges

         // read data, zero data in the error region
         if (r_fire)
         begin
            rvalid_q = 1'b0;
            ar_seen  = 1'b0;
            r_dly    = next_delay();
         end
         else if (ar_seen && !rvalid_q)
         begin
            if (r_dly == 0)
            begin
               r_q.data = (ar_q.addr < ERR_BASE) ? mem[ar_q.addr[10:3]] : '0;
               r_q.resp = (ar_q.addr < ERR_BASE) ? OKAY : SLVERR;
               r_q.last = 1'b1;
               rvalid_q = 1'b1;
            end
            else
               r_dly = r_dly - 1;
         end
         r_fire = rvalid_q && i_rready;
      end
   end

endmodule

/* tb_axi_bridge.sv */
// axi bridge testbench that runs pattern file requests through the bridge and checks responses
`timescale 1ns/1ps

module tb_axi_bridge;
   import axi_bridge_pkg::*;

   localparam string PATTERN_FILE = "axi_bridge_patterns.txt";
   localparam int    BATCH        = QUEUE_DEPTH;   // core runs at most four ahead
   localparam int    RSP_TIMEOUT  = 200;           // cycles allowed per response

   typedef struct packed {
      logic                 we;
      logic [ADDR_W-1:0]    addr;
      logic [PAYLOAD_W-1:0] wdata;
      logic [PAYLOAD_W-1:0] exp_rdata;
      logic                 exp_err;
   } pattern_t;

   logic        clk;
   logic        reset;
   logic        req_valid;
   bridge_req_t req;
   logic        rsp_valid;
   bridge_rsp_t rsp;
   axi_aw_t     aw;
   axi_w_t      w;
   axi_b_t      b;
   axi_ar_t     ar;
   axi_r_t      r;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;

   pattern_t    pats [$];
   string       names [$];
   bridge_rsp_t rsp_fifo [$];                      // responses in arrival order
   int          tests_run = 0;
   int          tests_ok  = 0;
   int          errors    = 0;
   bit          abort     = 1'b0;

   axi_bridge_top UUT (
      .clk(clk), .i_reset(reset), .i_req_valid(req_valid), .i_req(req),
      .o_rsp_valid(rsp_valid), .o_rsp(rsp),
      .o_aw(aw), .o_awvalid(awvalid), .i_awready(awready),
      .o_w(w), .o_wvalid(wvalid), .i_wready(wready),
      .i_b(b), .i_bvalid(bvalid), .o_bready(bready),
      .o_ar(ar), .o_arvalid(arvalid), .i_arready(arready),
      .i_r(r), .i_rvalid(rvalid), .o_rready(rready));

   tb_axi_mem u_mem (
      .clk(clk), .i_reset(reset),
      .i_aw(aw), .i_awvalid(awvalid), .o_awready(awready),
      .i_w(w), .i_wvalid(wvalid), .o_wready(wready),
      .o_b(b), .o_bvalid(bvalid), .i_bready(bready),
      .i_ar(ar), .i_arvalid(arvalid), .o_arready(arready),
      .o_r(r), .o_rvalid(rvalid), .i_rready(rready));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                      // 40 ns period
   end

   // response strobe is stable on the falling edge
   always @(negedge clk)
   begin
      if (!reset && rsp_valid)
         rsp_fifo.push_back(rsp);
   end

   // ################################################
   // every beat is one word in a single incr transfer
   // ################################################
   always @(negedge clk)
   begin
      if (!reset && awvalid)
      begin
         assert (aw.len == 8'd0 && aw.size == 3'd2 && aw.burst == 2'b01)
         else
         begin
            $display("mismatch aw_beat expected len/size/burst 0/2/1 actual %0d/%0d/%0d",
                     aw.len, aw.size, aw.burst);
            errors++;
         end
      end
      if (!reset && wvalid)
      begin
         assert (w.last == 1'b1)
         else
         begin
            $display("mismatch w_beat expected last 1 actual %0d", w.last);
            errors++;
         end
      end
      if (!reset && arvalid)
      begin
         assert (ar.len == 8'd0 && ar.size == 3'd2 && ar.burst == 2'b01)
         else
         begin
            $display("mismatch ar_beat expected len/size/burst 0/2/1 actual %0d/%0d/%0d",
                     ar.len, ar.size, ar.burst);
            errors++;
         end
      end
   end

   // ################################################
   // helpers
   // ################################################
   task automatic load_patterns();
      int          fd;
      int          code;
      string       name;
      string       op;
      string       rest;
      logic [31:0] addr, wdata, exp_rdata, err_v;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0)
      begin
         $display("cannot open pattern file %s", PATTERN_FILE);
         errors++;
         abort = 1'b1;
         return;
      end
      while (!$feof(fd))
      begin
         code = $fscanf(fd, "%s", name);
         if (code != 1)
            break;
         if (name.getc(0) == "#")
            code = $fgets(rest, fd);               // column notes
         else
         begin
            code = $fscanf(fd, "%s %h %h %h %h", op, addr, wdata, exp_rdata, err_v);
            if (code != 5)
            begin
               $display("pattern line for test %s is incomplete", name);
               errors++;
               abort = 1'b1;
               break;
            end
            names.push_back(name);
            pats.push_back('{we: (op == "W"), addr: addr, wdata: wdata,
                             exp_rdata: exp_rdata, exp_err: err_v[0]});
         end
      end
      $fclose(fd);
      if (pats.size() == 0 && !abort)
      begin
         $display("pattern file holds no tests");
         errors++;
         abort = 1'b1;
      end
   endtask

   task automatic wait_response(output bridge_rsp_t got_rsp, output bit got);
      int cycles;
      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < RSP_TIMEOUT)
      begin
         if (rsp_fifo.size() > 0)
         begin
            got_rsp = rsp_fifo.pop_front();
            got     = 1'b1;
         end
         else
         begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   task automatic check_response(input int idx, input bridge_rsp_t got_rsp);
      bit ok;
      ok = 1'b1;
      assert (got_rsp.rdata == pats[idx].exp_rdata)
      else
      begin
         $display("mismatch %s rdata expected %08h actual %08h",
                  names[idx], pats[idx].exp_rdata, got_rsp.rdata);
         ok = 1'b0;
      end
      assert (got_rsp.err == pats[idx].exp_err)
      else
      begin
         $display("mismatch %s err expected %0d actual %0d",
                  names[idx], pats[idx].exp_err, got_rsp.err);
         ok = 1'b0;
      end
      tests_run++;
      if (ok)
         tests_ok++;
      else
         errors++;
      $display("test %s %s", names[idx], ok ? "ok" : "error");
   endtask

   // ################################################
   // main sequence
   // ################################################
   initial
   begin
      int          next;
      int          n;
      bit          got;
      bridge_rsp_t got_rsp;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      load_patterns();
      repeat (2) @(posedge clk);                  // two cycles of reset
      @(negedge clk);
      reset = 1'b0;

      next = 0;
      while (!abort && next < pats.size())
      begin
         n = (pats.size() - next < BATCH) ? pats.size() - next : BATCH;
         for (int k = 0; k < n; k++)
         begin
            @(negedge clk);
            req_valid = 1'b1;                       // back to back strobes
            req       = '{we: pats[next+k].we, addr: pats[next+k].addr,
                          wdata: pats[next+k].wdata};
         end
         @(negedge clk);
         req_valid = 1'b0;
         for (int k = 0; k < n && !abort; k++)
         begin
            wait_response(got_rsp, got);
            if (got)
               check_response(next + k, got_rsp);
            else
            begin
               $display("test %s got no response within %0d cycles",
                        names[next+k], RSP_TIMEOUT);
               errors++;
               abort = 1'b1;
            end
         end
         next += n;
      end

      repeat (4) @(negedge clk);                   // room for a stray strobe
      assert (abort || rsp_fifo.size() == 0)
      else
      begin
         $display("bridge sent %0d responses that no request asked for", rsp_fifo.size());
         errors++;
      end

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_ok, tests_run - tests_ok, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* axi_bridge_patterns.txt */
# columns: name op(R/W) addr wdata exp_rdata exp_err, numbers in hex
# a write answers with zero read data, the error region starts at 80000000
lo_wr      W 00000010 11223344 00000000 0
lo_rd      R 00000010 00000000 11223344 0
hi_wr      W 00000014 55667788 00000000 0
hi_rd      R 00000014 00000000 55667788 0
lo_keep    R 00000010 00000000 11223344 0
hi_wr2     W 0000001c cafef00d 00000000 0
lo_untouch R 00000018 00000000 00000000 0
hi_rd2     R 0000001c 00000000 cafef00d 0
q_wr0      W 00000100 0badc0de 00000000 0
q_wr1      W 00000104 feedbeef 00000000 0
q_rd0      R 00000100 00000000 0badc0de 0
q_rd1      R 00000104 00000000 feedbeef 0
err_wr     W 80000000 deadbeef 00000000 1
err_rd     R 80000008 00000000 00000000 1
err_rd_top R fffffff4 00000000 00000000 1
after_err  R 00000104 00000000 feedbeef 0
fresh_lo   R 00000200 00000000 00000000 0
fresh_hi   R 000007fc 00000000 00000000 0
alias_chk  R 00000000 00000000 00000000 0
wr_back    W 000007fc 13579bdf 00000000 0
rd_back    R 000007fc 00000000 13579bdf 0

/* sources.f */
axi_bridge_pkg.sv
align_w.sv
align_r.sv
req_queue.sv
axi_txn_engine.sv
axi_bridge_top.sv
tb_axi_mem.sv
tb_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the axi bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
   --top-module tb_axi_bridge -o sim_axi_bridge

status=0
./obj_dir/sim_axi_bridge > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0
